//--- sources.f
+incdir+hdl
hdl/ecc_pkg.sv
hdl/ecc_check_if.sv
hdl/ecc_parity_gen.sv
hdl/ecc_syndrome_decode.sv
hdl/ecc_data_correct.sv
hdl/ecc_109_top.sv
sim/ecc_109_tb.sv

//--- Bender.yml
package:
  name: ecc_109

export_include_dirs:
  - hdl

sources:
  # design, in compile order
  - include_dirs:
      - hdl
    files:
      - hdl/ecc_pkg.sv
      - hdl/ecc_check_if.sv
      - hdl/ecc_parity_gen.sv
      - hdl/ecc_syndrome_decode.sv
      - hdl/ecc_data_correct.sv
      - hdl/ecc_109_top.sv

  # testbench
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/ecc_109_tb.sv

//--- sim/ecc_109_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_params.svh"

module ecc_109_tb;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 2;
    localparam int CW_W          = `ECC_DATA_W + `ECC_CHECK_W;  // 117-bit codeword view.
    localparam int N_CLEAN       = 200;
    localparam int N_DOUBLE      = 200;
    localparam int N_PER_MODE    = N_CLEAN + `ECC_DATA_W + `ECC_CHECK_W + N_DOUBLE;
    localparam int N_VECTORS     = 2 * N_PER_MODE;  // bypass low, then high.
    localparam int MARGIN_CYCLES = 50;
    localparam int TIMEOUT_NS    = (N_VECTORS + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    localparam logic [31:0] LFSR_SEED = 32'h2b3e_3f5e;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1.

    logic                    clk;
    logic                    rst_n;
    logic [`ECC_DATA_W-1:0]  data_in;
    logic [`ECC_DATA_W-1:0]  data_out;
    logic [`ECC_CHECK_W-1:0] parity_in;
    logic [`ECC_CHECK_W-1:0] parity_out;
    logic                    bypass;
    logic                    sbit_err;
    logic                    dbit_err;

    logic [31:0] lfsr_state;
    int          check_count;
    int          error_count;

    // expected responses, one entry per driven vector.
    logic [`ECC_DATA_W-1:0]  exp_data_q[$];
    logic [`ECC_CHECK_W-1:0] exp_parity_q[$];
    logic                    exp_sbit_q[$];
    logic                    exp_dbit_q[$];

    ecc_109_top ecc_109_top_inst (
        .data_in    (data_in),
        .data_out   (data_out),
        .parity_in  (parity_in),
        .parity_out (parity_out),
        .bypass     (bypass),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // one Galois step, shifting right.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // n random bits, one LFSR step each.
    task automatic take_bits(input int n, output logic [127:0] v);
        int k;

        v = '0;
        for (k = 0; k < n; k++) begin
            v          = {v[126:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic random_data(output logic [`ECC_DATA_W-1:0] d);
        logic [127:0] r;

        take_bits(`ECC_DATA_W, r);
        d = r[`ECC_DATA_W-1:0];
    endtask

    // reference encoder, walks the Hamming positions directly.
    // Position n from 3 up, powers of two skipped; the top bit pads the
    // column to odd weight.
    function automatic logic [`ECC_CHECK_W-1:0] ref_encode(input logic [`ECC_DATA_W-1:0] d);
        logic [`ECC_CHECK_W-1:0] c;
        logic [`ECC_POS_W-1:0]   pos;
        int                      n;
        int                      i;

        c = '0;
        i = 0;
        for (n = 3; i < `ECC_DATA_W; n++) begin
            if ($countones(n) != 1) begin
                pos = n[`ECC_POS_W-1:0];
                if (d[i]) begin
                    c = c ^ {~(^pos), pos};
                end
                i++;
            end
        end
        return c;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // drive one vector and queue what the outputs must be.
    task automatic apply_vector(input logic [`ECC_DATA_W-1:0]  d,
                                input logic [`ECC_CHECK_W-1:0] p,
                                input logic                    byp,
                                input logic [`ECC_DATA_W-1:0]  fixed,
                                input logic                    sbit,
                                input logic                    dbit);
        @(posedge clk);
        data_in   <= d;
        parity_in <= p;
        bypass    <= byp;
        exp_parity_q.push_back(ref_encode(d));
        if (byp) begin
            exp_data_q.push_back(d);  // bypass passes the data as received.
            exp_sbit_q.push_back(1'b0);
            exp_dbit_q.push_back(1'b0);
        end else begin
            exp_data_q.push_back(fixed);
            exp_sbit_q.push_back(sbit);
            exp_dbit_q.push_back(dbit);
        end
    endtask

    task automatic run_clean(input logic byp);
        logic [`ECC_DATA_W-1:0] d;
        int                     k;

        for (k = 0; k < N_CLEAN; k++) begin
            random_data(d);
            apply_vector(d, ref_encode(d), byp, d, 1'b0, 1'b0);
        end
    endtask

    task automatic run_data_flips(input logic byp);
        logic [`ECC_DATA_W-1:0] d;
        logic [`ECC_DATA_W-1:0] flip;
        int                     k;

        for (k = 0; k < `ECC_DATA_W; k++) begin
            random_data(d);
            flip    = '0;
            flip[k] = 1'b1;
            apply_vector(d ^ flip, ref_encode(d), byp, d, 1'b1, 1'b0);
        end
    endtask

    task automatic run_check_flips(input logic byp);
        logic [`ECC_DATA_W-1:0]  d;
        logic [`ECC_CHECK_W-1:0] flip;
        int                      k;

        for (k = 0; k < `ECC_CHECK_W; k++) begin
            random_data(d);
            flip    = '0;
            flip[k] = 1'b1;
            apply_vector(d, ref_encode(d) ^ flip, byp, d, 1'b1, 1'b0);
        end
    endtask

    // two distinct codeword bits, data or check.
    task automatic run_double(input logic byp);
        logic [`ECC_DATA_W-1:0] d;
        logic [CW_W-1:0]        cw;
        logic [127:0]           r;
        int                     p1;
        int                     p2;
        int                     k;

        for (k = 0; k < N_DOUBLE; k++) begin
            random_data(d);
            take_bits(7, r);
            p1 = int'(r[6:0]) % CW_W;
            take_bits(7, r);
            p2 = (p1 + 1 + (int'(r[6:0]) % (CW_W - 1))) % CW_W;  // never equals p1.
            cw     = {ref_encode(d), d};
            cw[p1] = ~cw[p1];
            cw[p2] = ~cw[p2];
            apply_vector(cw[`ECC_DATA_W-1:0], cw[CW_W-1:`ECC_DATA_W], byp,
                         cw[`ECC_DATA_W-1:0], 1'b0, 1'b1);
        end
    endtask

    // outputs settled half a cycle after the drive edge.
    always @(negedge clk) begin
        if (rst_n && exp_data_q.size() != 0) begin
            check_value("data_out", data_out, exp_data_q.pop_front());
            check_value("parity_out", parity_out, exp_parity_q.pop_front());
            check_value("sbit_err", sbit_err, exp_sbit_q.pop_front());
            check_value("dbit_err", dbit_err, exp_dbit_q.pop_front());
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout, the test vectors did not finish within %0d ns", TIMEOUT_NS);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        data_in     = '0;
        parity_in   = '0;
        bypass      = 1'b0;
        lfsr_state  = LFSR_SEED;
        check_count = 0;
        error_count = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        run_clean(1'b0);
        run_data_flips(1'b0);
        run_check_flips(1'b0);
        run_double(1'b0);

        run_clean(1'b1);  // same classes with bypass high.
        run_data_flips(1'b1);
        run_check_flips(1'b1);
        run_double(1'b1);

        while (exp_data_q.size() != 0) begin
            @(negedge clk);
        end

        $display("vectors %0d, checks %0d, errors %0d", N_VECTORS, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/ecc_109_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_params.svh"

module ecc_109_top (
    input  logic [`ECC_DATA_W-1:0]  data_in,
    output logic [`ECC_DATA_W-1:0]  data_out,
    input  logic [`ECC_CHECK_W-1:0] parity_in,
    output logic [`ECC_CHECK_W-1:0] parity_out,
    input  logic                    bypass,
    output logic                    sbit_err,
    output logic                    dbit_err
);

    ecc_check_if dec_if ();

    // check bits of the received data.
    ecc_parity_gen ecc_parity_gen_inst (
        .data  (data_in),
        .check (parity_out)
    );

    ecc_syndrome_decode ecc_syndrome_decode_inst (
        .check_rx   (parity_in),
        .check_calc (parity_out),  // also the encoder output.
        .dec        (dec_if.decode)
    );

    ecc_data_correct ecc_data_correct_inst (
        .data_rx  (data_in),
        .bypass   (bypass),
        .dec      (dec_if.correct),
        .data_fix (data_out),
        .sbit_err (sbit_err),
        .dbit_err (dbit_err)
    );

endmodule

`default_nettype wire

//--- hdl/ecc_data_correct.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_data_correct (
    input  ecc_pkg::data_t data_rx,
    input  logic           bypass,
    ecc_check_if.correct   dec,
    output ecc_pkg::data_t data_fix,
    output logic           sbit_err,
    output logic           dbit_err
);

    logic fix_en;

    assign fix_en = dec.flip_hit & ~bypass;

    // invert the one bad data bit.
    always_comb begin
        data_fix = data_rx;
        if (fix_en) begin
            data_fix[dec.flip_index] = ~data_rx[dec.flip_index];
        end
    end

    // flags silenced in bypass.
    assign sbit_err = dec.single_err & ~bypass;
    assign dbit_err = dec.double_err & ~bypass;

endmodule

`default_nettype wire

//--- hdl/ecc_syndrome_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_params.svh"

module ecc_syndrome_decode (
    input  ecc_pkg::check_t check_rx,
    input  ecc_pkg::check_t check_calc,
    ecc_check_if.decode     dec
);

    ecc_pkg::check_t   syndrome;
    wire ecc_pkg::data_t col_match;   // one bit per data column.
    logic              hit;
    ecc_pkg::bit_idx_t idx;
    logic              check_bit_err;
    logic              nonzero;
    logic              single;

    assign syndrome = check_rx ^ check_calc;
    assign nonzero  = |syndrome;

    // compare against every data column.
    for (genvar i = 0; i < `ECC_DATA_W; i++) begin : g_col
        localparam ecc_pkg::check_t COL = ecc_pkg::data_column(i);

        assign col_match[i] = (syndrome == COL);
    end

    // columns are distinct, so at most one match.
    always_comb begin
        hit = |col_match;
        idx = '0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            if (col_match[i]) begin
                idx = ecc_pkg::bit_idx_t'(i);
            end
        end
    end

    // a lone set bit means a flipped check bit. Nothing to correct in data.
    assign check_bit_err = nonzero && ((syndrome & (syndrome - 1'b1)) == '0);

    assign single = hit | check_bit_err;

    // Data columns have odd weight, so two flips give an even, nonzero
    // syndrome that neither matches a column nor has one set bit.
    assign dec.flip_hit   = hit;
    assign dec.flip_index = idx;
    assign dec.single_err = single;
    assign dec.double_err = nonzero & ~single;

endmodule

`default_nettype wire

//--- hdl/ecc_parity_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_params.svh"

module ecc_parity_gen (
    input  ecc_pkg::data_t  data,
    output ecc_pkg::check_t check
);

    // row b of the H matrix, i.e. the data bits that feed check bit b.
    function automatic ecc_pkg::data_t row_mask(input int unsigned b);
        ecc_pkg::data_t  m;
        ecc_pkg::check_t col;
        int unsigned     i;

        m = '0;
        for (i = 0; i < `ECC_DATA_W; i++) begin
            col  = ecc_pkg::data_column(i);
            m[i] = col[b];
        end
        return m;
    endfunction

    // one XOR tree per check bit.
    for (genvar b = 0; b < `ECC_CHECK_W; b++) begin : g_check
        localparam ecc_pkg::data_t ROW = row_mask(b);

        assign check[b] = ^(data & ROW);  // rows fixed at elaboration.
    end

endmodule

`default_nettype wire

//--- hdl/ecc_check_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded syndrome, decoder to corrector.
interface ecc_check_if;

    logic             flip_hit;    // syndrome equals a data column.
    ecc_pkg::bit_idx_t flip_index;  // data bit to invert.
    logic             single_err;  // data or check bit error.
    logic             double_err;  // uncorrectable.

    modport decode (
        output flip_hit,
        output flip_index,
        output single_err,
        output double_err
    );

    modport correct (
        input flip_hit,
        input flip_index,
        input single_err,
        input double_err
    );

endinterface

`default_nettype wire

//--- hdl/ecc_pkg.sv
`default_nettype none

`include "ecc_params.svh"

package ecc_pkg;

    typedef logic [`ECC_DATA_W-1:0]  data_t;     // one data word.
    typedef logic [`ECC_CHECK_W-1:0] check_t;    // check word or syndrome.
    typedef logic [`ECC_POS_W-1:0]   bit_idx_t;  // index of a data bit.

    // H matrix column of data bit idx.
    // Data bit i sits at the i-th position from 3 upward that is not a
    // power of two. The low bits hold that position. The top bit makes
    // the column weight odd.
    function automatic check_t data_column(input int unsigned idx);
        int unsigned           pos;
        int unsigned           cnt;
        int unsigned           n;
        int unsigned           ones;
        logic [`ECC_POS_W-1:0] code;
        logic                  even;

        pos = 0;
        cnt = 0;
        for (n = 3; n < (1 << `ECC_POS_W); n++) begin
            if ((n & (n - 1)) != 0) begin  // powers of two are skipped.
                if (cnt == idx) begin
                    pos = n;
                end
                cnt++;
            end
        end

        code = pos[`ECC_POS_W-1:0];
        ones = 0;
        for (n = 0; n < `ECC_POS_W; n++) begin
            ones += code[n];
        end
        even = ~ones[0];  // pad even weight to odd.

        return {even, code};
    endfunction

endpackage

`default_nettype wire

//--- hdl/ecc_params.svh
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

// widths of the 109/8 secded code.

// data word width.
`define ECC_DATA_W  109

// check word width, also the syndrome width.
`define ECC_CHECK_W 8

// Hamming position width. It is also wide enough for a data bit index.
`define ECC_POS_W   7

`endif
